// ==== Makefile ====
TOP := tb_spi_master

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== design/spi_cmd_capture.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "spi_master_defs.svh"

module spi_cmd_capture
  import spi_master_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_req,
  input  spi_cmd_u   cmd,
  output logic       cmd_ack,
  output logic       frm_req,
  output spi_frame_t frm,
  input  logic       frm_ack
);

  spi_frame_t frm_next;
  logic       take_cmd;

  // the stage is empty only once the previous frame link has fully closed
  assign take_cmd = cmd_req && !cmd_ack && !frm_req && !frm_ack;

  always_comb
  begin
    frm_next = '0;
    if (cmd.wr.rw)
    begin
      frm_next.shift   = {cmd.wr.rw, cmd.wr.addr, cmd.wr.wdata};
      frm_next.tx_bits = spi_bit_cnt_t'(`SPI_CMD_WIDTH);
      frm_next.is_read = 1'b0;
    end
    else
    begin
      // header goes out left-aligned, the data byte comes back on miso
      frm_next.shift   = {cmd.rd.rw, cmd.rd.addr,
                          {(`SPI_CMD_WIDTH - `SPI_HDR_WIDTH){1'b0}}};
      frm_next.tx_bits = spi_bit_cnt_t'(`SPI_HDR_WIDTH);
      frm_next.is_read = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_ack <= 1'b0;
      frm_req <= 1'b0;
    end
    else
    begin
      if (take_cmd)
        cmd_ack <= 1'b1;
      else if (cmd_ack && !cmd_req)
        cmd_ack <= 1'b0;

      // frame request goes up together with the host ack
      if (take_cmd)
        frm_req <= 1'b1;
      else if (frm_req && frm_ack)
        frm_req <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take_cmd)
      frm <= frm_next;
  end

endmodule

`default_nettype wire

// ==== design/spi_frame_engine.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "spi_master_defs.svh"

module spi_frame_engine
  import spi_master_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           frm_req,
  input  spi_frame_t     frm,
  output logic           frm_ack,
  output logic           res_req,
  output spi_rd_result_t res,
  input  logic           res_ack,
  output logic           sclk,
  output logic           cs_n,
  output logic           mosi,
  input  logic           miso
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_TX,
    ST_RX,
    ST_FINISH
  } state_t;

  localparam int DIV_W = $clog2(`SPI_CLK_DIV);

  state_t                     state;
  logic [DIV_W-1:0]           div_cnt;
  logic                       half_tick;
  logic                       start;
  spi_bit_cnt_t               bit_cnt;
  spi_bit_cnt_t               bit_cnt_inc;
  spi_bit_cnt_t               tx_bits;
  logic                       is_read;
  logic [`SPI_CMD_WIDTH-1:0]  tx_shift;
  logic [`SPI_READ_WIDTH-1:0] rx_shift;
  logic [`SPI_ADDR_WIDTH-1:0] addr;

  // hold off while a read result is still in its handshake
  assign start       = (state == ST_IDLE) && frm_req && !frm_ack && !res_req && !res_ack;
  assign half_tick   = (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
  assign bit_cnt_inc = bit_cnt + 1'b1;
  assign mosi        = !cs_n && tx_shift[`SPI_CMD_WIDTH-1];
  assign res         = '{addr: addr, data: rx_shift};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (state == ST_IDLE || half_tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      frm_ack <= 1'b0;
      res_req <= 1'b0;
      bit_cnt <= '0;
    end
    else
    begin
      if (frm_ack && !frm_req)
        frm_ack <= 1'b0;
      if (res_req && res_ack)
        res_req <= 1'b0;

      case (state)
        ST_IDLE:
          if (start)
          begin
            frm_ack <= 1'b1;
            cs_n    <= 1'b0;
            bit_cnt <= '0;
            state   <= ST_SETUP;
          end
        // first low half period lets mosi settle before the first rising edge
        ST_SETUP:
          if (half_tick)
          begin
            sclk  <= 1'b1;
            state <= ST_TX;
          end
        ST_TX:
          if (half_tick)
          begin
            sclk <= !sclk;
            if (sclk)
            begin
              bit_cnt <= bit_cnt_inc;
              if (bit_cnt_inc == tx_bits)
              begin
                bit_cnt <= '0;
                state   <= is_read ? ST_RX : ST_FINISH;
              end
            end
          end
        ST_RX:
          if (half_tick)
          begin
            sclk <= !sclk;
            if (sclk)
            begin
              bit_cnt <= bit_cnt_inc;
              if (bit_cnt_inc == spi_bit_cnt_t'(`SPI_READ_WIDTH))
                state <= ST_FINISH;
            end
          end
        ST_FINISH:
          if (half_tick)
          begin
            cs_n  <= 1'b1;
            state <= ST_IDLE;
            if (is_read)
              res_req <= 1'b1;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // mosi moves on falling edges, miso is taken on rising edges
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      tx_shift <= frm.shift;
      tx_bits  <= frm.tx_bits;
      is_read  <= frm.is_read;
      addr     <= frm.shift[`SPI_CMD_WIDTH-2 -: `SPI_ADDR_WIDTH];
    end
    else if (state == ST_TX && half_tick && sclk)
      tx_shift <= {tx_shift[`SPI_CMD_WIDTH-2:0], 1'b0};

    if (state == ST_RX && half_tick && !sclk)
      rx_shift <= {rx_shift[`SPI_READ_WIDTH-2:0], miso};
  end

endmodule

`default_nettype wire

// ==== design/spi_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_master
  import spi_master_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           cmd_req,
  input  spi_cmd_u       cmd,
  output logic           cmd_ack,
  output logic           rd_req,
  output spi_rd_result_t rd,
  input  logic           rd_ack,
  output logic           sclk,
  output logic           cs_n,
  output logic           mosi,
  input  logic           miso
);

  logic           frm_req;
  logic           frm_ack;
  spi_frame_t     frm;
  logic           res_req;
  logic           res_ack;
  spi_rd_result_t res;

  spi_cmd_capture u_capture (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .frm_req (frm_req),
    .frm     (frm),
    .frm_ack (frm_ack)
  );

  spi_frame_engine u_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .frm_req (frm_req),
    .frm     (frm),
    .frm_ack (frm_ack),
    .res_req (res_req),
    .res     (res),
    .res_ack (res_ack),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

  spi_read_return u_return (
    .clk     (clk),
    .rst_n   (rst_n),
    .res_req (res_req),
    .res     (res),
    .res_ack (res_ack),
    .rd_req  (rd_req),
    .rd      (rd),
    .rd_ack  (rd_ack)
  );

endmodule

`default_nettype wire

// ==== design/spi_master_defs.svh ====
`ifndef SPI_MASTER_DEFS_SVH
`define SPI_MASTER_DEFS_SVH

// full command word, MSB first on the wire
`define SPI_CMD_WIDTH 12

// data returned by a read
`define SPI_READ_WIDTH 8

// register address inside the peripheral
`define SPI_ADDR_WIDTH 3

// rw bit plus address, the part of a read that is sent
`define SPI_HDR_WIDTH 4

// clk cycles per sclk half period
`define SPI_CLK_DIV 4

`endif

// ==== design/spi_master_pkg.sv ====
`default_nettype none
`include "spi_master_defs.svh"

package spi_master_pkg;

  typedef struct packed {
    logic                       rw;
    logic [`SPI_ADDR_WIDTH-1:0] addr;
    logic [`SPI_READ_WIDTH-1:0] wdata;
  } spi_cmd_wr_t;

  // low byte carries nothing on a read
  typedef struct packed {
    logic                       rw;
    logic [`SPI_ADDR_WIDTH-1:0] addr;
    logic [`SPI_READ_WIDTH-1:0] rsvd;
  } spi_cmd_rd_t;

  typedef union packed {
    spi_cmd_wr_t wr;
    spi_cmd_rd_t rd;
  } spi_cmd_u;

  // wide enough to count every bit of the longest frame
  typedef logic [$clog2(`SPI_CMD_WIDTH + 1)-1:0] spi_bit_cnt_t;

  typedef struct packed {
    logic [`SPI_CMD_WIDTH-1:0] shift;
    spi_bit_cnt_t              tx_bits;
    logic                      is_read;
  } spi_frame_t;

  typedef struct packed {
    logic [`SPI_ADDR_WIDTH-1:0] addr;
    logic [`SPI_READ_WIDTH-1:0] data;
  } spi_rd_result_t;

endpackage

`default_nettype wire

// ==== design/spi_read_return.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_read_return
  import spi_master_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           res_req,
  input  spi_rd_result_t res,
  output logic           res_ack,
  output logic           rd_req,
  output spi_rd_result_t rd,
  input  logic           rd_ack
);

  logic take_res;

  assign take_res = res_req && !res_ack && !rd_req && !rd_ack;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      res_ack <= 1'b0;
      rd_req  <= 1'b0;
    end
    else if (take_res)
    begin
      res_ack <= 1'b1;
      rd_req  <= 1'b1;
    end
    else
    begin
      if (rd_req && rd_ack)
        rd_req <= 1'b0;
      // ack stays up so the engine waits until the host has the result
      if (res_ack && !res_req && (!rd_req || rd_ack))
        res_ack <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take_res)
      rd <= res;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/spi_master_pkg.sv
design/spi_cmd_capture.sv
design/spi_frame_engine.sv
design/spi_read_return.sv
design/spi_master.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

// ==== verification/spi_slave_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "spi_master_defs.svh"

module spi_slave_model (
  input  wire logic sclk,
  input  wire logic cs_n,
  input  wire logic mosi,
  output logic      miso
);

  logic [`SPI_READ_WIDTH-1:0] regs [0:(1 << `SPI_ADDR_WIDTH)-1];
  logic [`SPI_CMD_WIDTH-1:0]  word;
  logic [`SPI_HDR_WIDTH-1:0]  hdr;
  int                         rise_cnt;

  initial
  begin
    miso = 1'b0;
    hdr  = '0;
    for (int n = 0; n < (1 << `SPI_ADDR_WIDTH); n++)
      regs[n] = 8'(n * 8'h11);
  end

  always @(negedge cs_n)
  begin
    rise_cnt = 0;
    word     = '0;
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      word     = {word[`SPI_CMD_WIDTH-2:0], mosi};
      rise_cnt = rise_cnt + 1;
      if (rise_cnt == `SPI_HDR_WIDTH)
        hdr = word[`SPI_HDR_WIDTH-1:0];
    end
  end

  // read data goes out MSB first, starting on the falling edge that ends the header
  always @(negedge sclk)
  begin
    if (!cs_n && !hdr[`SPI_HDR_WIDTH-1] && rise_cnt >= `SPI_HDR_WIDTH
        && rise_cnt < `SPI_CMD_WIDTH)
      miso <= regs[hdr[`SPI_ADDR_WIDTH-1:0]][`SPI_CMD_WIDTH-1-rise_cnt];
  end

  always @(posedge cs_n)
  begin
    if (rise_cnt == `SPI_CMD_WIDTH && word[`SPI_CMD_WIDTH-1])
      regs[word[`SPI_CMD_WIDTH-2 -: `SPI_ADDR_WIDTH]] = word[`SPI_READ_WIDTH-1:0];
  end

endmodule

`default_nettype wire

// ==== verification/tb_spi_master.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "spi_master_defs.svh"

module tb_spi_master
  import spi_master_pkg::*;
;

  localparam int NUM_CMDS = 40;
  localparam int FRAME_CYCLES = `SPI_CMD_WIDTH * 2 * `SPI_CLK_DIV;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * (FRAME_CYCLES + 20) + 200;

  logic           clk;
  logic           rst_n;
  logic           cmd_req;
  spi_cmd_u       cmd;
  logic           cmd_ack;
  logic           rd_req;
  spi_rd_result_t rd;
  logic           rd_ack;
  logic           sclk;
  logic           cs_n;
  logic           mosi;
  logic           miso;

  logic [`SPI_READ_WIDTH-1:0] mirror [0:(1 << `SPI_ADDR_WIDTH)-1];
  logic [`SPI_CMD_WIDTH-1:0]  frame_q [$];
  spi_rd_result_t             read_q [$];

  spi_master u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rd_req  (rd_req),
    .rd      (rd),
    .rd_ack  (rd_ack),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

  spi_slave_model u_slave (
    .sclk (sclk),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    $display("Simulation failed");
    $fatal(1, "value check failed");
  endtask

  task automatic report_fault(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "protocol check failed");
  endtask

  always #20 clk = ~clk;

  assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk)
    else report_fault("sclk toggled while cs_n was high");
  assert property (@(posedge clk) disable iff (!rst_n) $rose(cmd_ack) |-> $past(cmd_req))
    else report_fault("cmd_ack rose without cmd_req");
  assert property (@(posedge clk) disable iff (!rst_n) $fell(cmd_ack) |-> !$past(cmd_req))
    else report_fault("cmd_ack fell while cmd_req was still high");
  assert property (@(posedge clk) disable iff (!rst_n) $rose(rd_req) |-> !$past(rd_ack))
    else report_fault("rd_req rose while rd_ack was still high");
  assert property (@(posedge clk) disable iff (!rst_n) $fell(rd_req) |-> $past(rd_ack))
    else report_fault("rd_req fell before rd_ack was raised");
  assert property (@(posedge clk) disable iff (!rst_n) (rd_req && $past(rd_req)) |-> $stable(rd))
    else report_fault("rd changed while rd_req was high");
  assert property (@(posedge clk) disable iff (!rst_n) $fell(cs_n) |-> !$past(rd_req))
    else report_fault("a frame started while a read result was still waiting");

  // each frame is checked once the slave has finished with it
  always @(posedge cs_n)
  begin
    logic [`SPI_CMD_WIDTH-1:0] exp;
    #1;
    if (rst_n)
    begin
      if (frame_q.size() == 0)
        report_fault("a frame appeared with no command issued");
      exp = frame_q.pop_front();
      assert (u_slave.rise_cnt == `SPI_CMD_WIDTH)
        else report_mismatch("sclk edges", `SPI_CMD_WIDTH, u_slave.rise_cnt);
      if (exp[`SPI_CMD_WIDTH-1])
      begin
        assert (u_slave.word == exp)
          else report_mismatch("write bits", exp, u_slave.word);
        assert (u_slave.regs[exp[10:8]] == exp[7:0])
          else report_mismatch("slave register", exp[7:0], u_slave.regs[exp[10:8]]);
      end
      else
        assert (u_slave.word[11:8] == exp[11:8])
          else report_mismatch("read header", exp[11:8], u_slave.word[11:8]);
    end
  end

  // host side of the read link, with a random delay before each ack
  initial
  begin
    logic [31:0]    s;
    spi_rd_result_t exp;
    s = lcg_next(32'h858e7220);
    forever
    begin
      @(posedge clk);
      if (rd_req && !rd_ack)
      begin
        if (read_q.size() == 0)
          report_fault("a read result arrived with no read pending");
        exp = read_q.pop_front();
        assert (rd.addr == exp.addr)
          else report_mismatch("read addr", exp.addr, rd.addr);
        assert (rd.data == exp.data)
          else report_mismatch("read data", exp.data, rd.data);
        s = lcg_next(s);
        repeat (s[18:16] % 7)
          @(posedge clk);
        rd_ack <= 1'b1;
        @(posedge clk);
        while (rd_req)
          @(posedge clk);
        rd_ack <= 1'b0;
      end
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * 40);
    $display("timeout: the commands did not all complete in time");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    logic [31:0] s;
    spi_cmd_u    c;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_req = 1'b0;
    cmd     = '0;
    rd_ack  = 1'b0;
    s       = 32'h858e7220;
    for (int n = 0; n < (1 << `SPI_ADDR_WIDTH); n++)
      mirror[n] = 8'(n * 8'h11);
    repeat (5)
      @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    assert (cs_n && !sclk && !cmd_ack && !rd_req)
      else report_fault("outputs not in their reset state after reset");

    for (int i = 0; i < NUM_CMDS; i++)
    begin
      s = lcg_next(s);
      c.wr.rw    = s[20];
      c.wr.addr  = s[26:24];
      c.wr.wdata = s[15:8];
      frame_q.push_back(c);
      if (c.wr.rw)
        mirror[c.wr.addr] = c.wr.wdata;
      else
        read_q.push_back(spi_rd_result_t'{addr: c.rd.addr, data: mirror[c.rd.addr]});
      cmd     <= c;
      cmd_req <= 1'b1;
      @(posedge clk);
      while (!cmd_ack)
        @(posedge clk);
      cmd_req <= 1'b0;
      @(posedge clk);
      while (cmd_ack)
        @(posedge clk);
    end

    while (frame_q.size() != 0 || read_q.size() != 0 || rd_req)
      @(posedge clk);
    repeat (10)
      @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
